// File: src/cpu_pkg.sv
/*
 * RV32I core definitions
 * Widths, vector types, major opcodes and ALU operation codes shared by
 * the fetch, decode, execute and result stages
 */
package cpu_pkg;

    localparam int NB_DATA     = 32;  // Register and ALU width
    localparam int NB_INSTR    = 32;
    localparam int NB_PC       = 32;  // Byte address
    localparam int NB_REG_ADDR = 5;

    typedef logic [NB_DATA-1:0]     data_t;
    typedef logic [NB_INSTR-1:0]    instr_t;
    typedef logic [NB_PC-1:0]       pc_t;
    typedef logic [NB_REG_ADDR-1:0] reg_addr_t;

    // Major opcode, instr[6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ALU operation, chosen in decode
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;  // Signed compare
    localparam alu_op_t ALU_SLL    = 4'd6;
    localparam alu_op_t ALU_SRL    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8;  // Operand B straight through, LUI

endpackage

// File: src/fetch_unit.sv
/*
 * Fetch stage
 * Program counter, word-wide instruction memory with an external load
 * port, and the fetch/decode register
 */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int IMEM_ADDR_WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,
    input  logic                       i_imem_wen,
    input  logic [IMEM_ADDR_WIDTH-1:0] i_imem_waddr,
    input  cpu_pkg::instr_t            i_imem_data,
    output cpu_pkg::pc_t               o_pc,
    output cpu_pkg::instr_t            o_instr,
    output cpu_pkg::instr_t            o_id_instr
);

    import cpu_pkg::*;

    localparam int IMEM_WORDS = 2 ** (IMEM_ADDR_WIDTH - 2);

    instr_t imem [IMEM_WORDS];

    logic [IMEM_ADDR_WIDTH-3:0] rd_word;
    logic [IMEM_ADDR_WIDTH-3:0] wr_word;

    assign rd_word = o_pc[IMEM_ADDR_WIDTH-1:2];   // PC truncated to memory size
    assign wr_word = i_imem_waddr[IMEM_ADDR_WIDTH-1:2];

    // Load port works whether or not the core is enabled
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < IMEM_WORDS; i++) begin
                imem[i] <= '0;
            end
        end else if (i_imem_wen) begin
            imem[wr_word] <= i_imem_data;
        end
    end

    assign o_instr = imem[rd_word];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc       <= '0;
            o_id_instr <= '0;  // All-zero word decodes as no-op
        end else if (i_en) begin
            o_pc       <= o_pc + pc_t'(4);
            o_id_instr <= o_instr;
        end
    end

endmodule

// File: src/reg_file.sv
/*
 * Integer register file
 * 31 writable registers, x0 reads zero, two combinational read ports
 * with write-through of a same-cycle write
 */
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               i_rst_n,
    input  cpu_pkg::reg_addr_t i_raddr1,
    input  cpu_pkg::reg_addr_t i_raddr2,
    input  logic               i_wen,
    input  cpu_pkg::reg_addr_t i_waddr,
    input  cpu_pkg::data_t     i_wdata,
    output cpu_pkg::data_t     o_rdata1,
    output cpu_pkg::data_t     o_rdata2
);

    import cpu_pkg::*;

    data_t regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wen && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Bypass the value being written this cycle
    always_comb begin
        if (i_raddr1 == '0)
            o_rdata1 = '0;
        else if (i_wen && (i_waddr == i_raddr1))
            o_rdata1 = i_wdata;
        else
            o_rdata1 = regs[i_raddr1];

        if (i_raddr2 == '0)
            o_rdata2 = '0;
        else if (i_wen && (i_waddr == i_raddr2))
            o_rdata2 = i_wdata;
        else
            o_rdata2 = regs[i_raddr2];
    end

endmodule

// File: src/decode_unit.sv
/*
 * Decode stage
 * Control and immediate decode, register file reads with the debug
 * address override, and the decode/execute register
 */
`timescale 1ns/1ps

module decode_unit (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_en,
    input  cpu_pkg::instr_t    i_id_instr,
    input  logic               i_du_rgfile_rd,
    input  cpu_pkg::reg_addr_t i_regfile_addr,
    input  logic               i_wb_wen,
    input  cpu_pkg::reg_addr_t i_wb_rd,
    input  cpu_pkg::data_t     i_wb_data,
    output cpu_pkg::data_t     o_regfile_data,
    output cpu_pkg::data_t     o_ex_rs1_data,
    output cpu_pkg::data_t     o_ex_rs2_data,
    output cpu_pkg::data_t     o_ex_imm,
    output cpu_pkg::reg_addr_t o_ex_rs1,
    output cpu_pkg::reg_addr_t o_ex_rs2,
    output cpu_pkg::reg_addr_t o_ex_rd,
    output cpu_pkg::alu_op_t   o_ex_alu_op,
    output logic               o_ex_alu_src_imm,
    output logic               o_ex_reg_write,
    output logic               o_ex_mem_read,
    output logic               o_ex_mem_write
);

    import cpu_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1, rs2, rd;
    reg_addr_t  raddr1;
    data_t      rdata1, rdata2;

    alu_op_t alu_op;
    data_t   imm;
    logic    alu_src_imm, reg_write, mem_read, mem_write;

    assign opcode = i_id_instr[6:0];
    assign rd     = i_id_instr[11:7];
    assign funct3 = i_id_instr[14:12];
    assign rs1    = i_id_instr[19:15];
    assign rs2    = i_id_instr[24:20];
    assign funct7 = i_id_instr[31:25];

    assign raddr1         = i_du_rgfile_rd ? i_regfile_addr : rs1;  // Debug read override
    assign o_regfile_data = rdata1;

    reg_file u_reg_file (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_raddr1 (raddr1),
        .i_raddr2 (rs2),
        .i_wen    (i_wb_wen),
        .i_waddr  (i_wb_rd),
        .i_wdata  (i_wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        imm         = {{20{i_id_instr[31]}}, i_id_instr[31:20]};  // I-type unless overridden
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;  // SLTU not supported
                endcase
            end
            OPC_OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;  // Shift-immediates dropped
                endcase
            end
            OPC_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
            end
            OPC_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                imm         = {{20{i_id_instr[31]}}, i_id_instr[31:25], i_id_instr[11:7]};
            end
            OPC_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = ALU_PASS_B;
                imm         = {i_id_instr[31:12], 12'b0};
            end
            default: ;  // Everything else is a no-op
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_reg_write <= 1'b0;
            o_ex_mem_read  <= 1'b0;
            o_ex_mem_write <= 1'b0;
        end else if (i_en) begin
            o_ex_reg_write <= reg_write;
            o_ex_mem_read  <= mem_read;
            o_ex_mem_write <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_ex_rs1_data    <= rdata1;
            o_ex_rs2_data    <= rdata2;
            o_ex_imm         <= imm;
            o_ex_rs1         <= rs1;
            o_ex_rs2         <= rs2;
            o_ex_rd          <= rd;
            o_ex_alu_op      <= alu_op;
            o_ex_alu_src_imm <= alu_src_imm;
        end
    end

endmodule

// File: src/execute_unit.sv
/*
 * Execute stage
 * Operand forwarding from the result stage, operand B select, ALU and
 * the execute/result register
 */
`timescale 1ns/1ps

module execute_unit (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_en,
    input  cpu_pkg::data_t     i_ex_rs1_data,
    input  cpu_pkg::data_t     i_ex_rs2_data,
    input  cpu_pkg::data_t     i_ex_imm,
    input  cpu_pkg::reg_addr_t i_ex_rs1,
    input  cpu_pkg::reg_addr_t i_ex_rs2,
    input  cpu_pkg::reg_addr_t i_ex_rd,
    input  cpu_pkg::alu_op_t   i_ex_alu_op,
    input  logic               i_ex_alu_src_imm,
    input  logic               i_ex_reg_write,
    input  logic               i_ex_mem_read,
    input  logic               i_ex_mem_write,
    input  logic               i_res_wen,
    input  cpu_pkg::reg_addr_t i_res_rd,
    input  cpu_pkg::data_t     i_res_data,
    output cpu_pkg::data_t     o_res_alu,
    output cpu_pkg::data_t     o_res_store_data,
    output cpu_pkg::reg_addr_t o_res_rd,
    output logic               o_res_reg_write,
    output logic               o_res_mem_read,
    output logic               o_res_mem_write
);

    import cpu_pkg::*;

    logic  fwd_a, fwd_b;
    data_t op_a, rs2_val, op_b;
    data_t alu_result;

    // Result stage is the only older instruction not yet in the register file
    assign fwd_a = i_res_wen && (i_res_rd != '0) && (i_res_rd == i_ex_rs1);
    assign fwd_b = i_res_wen && (i_res_rd != '0) && (i_res_rd == i_ex_rs2);

    assign op_a    = fwd_a ? i_res_data : i_ex_rs1_data;
    assign rs2_val = fwd_b ? i_res_data : i_ex_rs2_data;
    assign op_b    = i_ex_alu_src_imm ? i_ex_imm : rs2_val;

    always_comb begin
        case (i_ex_alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = data_t'($signed(op_a) < $signed(op_b));
            ALU_SLL:    alu_result = op_a << op_b[4:0];  // Shift amount from low 5 bits
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res_reg_write <= 1'b0;
            o_res_mem_read  <= 1'b0;
            o_res_mem_write <= 1'b0;
        end else if (i_en) begin
            o_res_reg_write <= i_ex_reg_write;
            o_res_mem_read  <= i_ex_mem_read;
            o_res_mem_write <= i_ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_res_alu        <= alu_result;
            o_res_store_data <= rs2_val;  // Forwarded rs2 for SW
            o_res_rd         <= i_ex_rd;
        end
    end

endmodule

// File: src/result_unit.sv
/*
 * Result stage
 * Word-wide data memory with combinational loads, and selection of the
 * register write-back value
 */
`timescale 1ns/1ps

module result_unit #(
    parameter int DMEM_ADDR_WIDTH = 5
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_en,
    input  cpu_pkg::data_t     i_res_alu,
    input  cpu_pkg::data_t     i_res_store_data,
    input  cpu_pkg::reg_addr_t i_res_rd,
    input  logic               i_res_reg_write,
    input  logic               i_res_mem_read,
    input  logic               i_res_mem_write,
    output logic               o_wb_wen,
    output cpu_pkg::reg_addr_t o_wb_rd,
    output cpu_pkg::data_t     o_wb_data
);

    import cpu_pkg::*;

    localparam int DMEM_WORDS = 2 ** (DMEM_ADDR_WIDTH - 2);

    data_t dmem [DMEM_WORDS];

    logic [DMEM_ADDR_WIDTH-3:0] word_addr;

    assign word_addr = i_res_alu[DMEM_ADDR_WIDTH-1:2];  // Byte address truncated, word aligned

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_en && i_res_mem_write) begin
            dmem[word_addr] <= i_res_store_data;
        end
    end

    // Loads never stall since the read is combinational
    assign o_wb_data = i_res_mem_read ? dmem[word_addr] : i_res_alu;
    assign o_wb_rd   = i_res_rd;
    assign o_wb_wen  = i_res_reg_write & i_en;

endmodule

// File: src/cpu_core.sv
/*
 * RV32I core top level
 * Four in-order stages: fetch, decode, execute and result, with forwarding
 * from the result stage and a debug read of the register file
 */
`timescale 1ns/1ps

module cpu_core #(
    parameter int IMEM_ADDR_WIDTH = 8,  // 64 instruction words
    parameter int DMEM_ADDR_WIDTH = 5   // 8 data words
) (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_en,
    input  logic                       i_imem_wen,
    input  logic [IMEM_ADDR_WIDTH-1:0] i_imem_waddr,
    input  cpu_pkg::instr_t            i_imem_data,
    input  logic                       i_du_rgfile_rd,
    input  cpu_pkg::reg_addr_t         i_regfile_addr,
    output cpu_pkg::pc_t               o_pc,
    output cpu_pkg::instr_t            o_instr,
    output cpu_pkg::data_t             o_regfile_data
);

    import cpu_pkg::*;

    instr_t    id_instr;

    // Decode to execute
    data_t     ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    alu_op_t   ex_alu_op;
    logic      ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;

    // Execute to result
    data_t     res_alu, res_store_data;
    reg_addr_t res_rd;
    logic      res_reg_write, res_mem_read, res_mem_write;

    // Write-back, also the forwarding source
    logic      wb_wen;
    reg_addr_t wb_rd;
    data_t     wb_data;

    fetch_unit #(
        .IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH)
    ) u_fetch_unit (
        .clk (clk), .i_rst_n (i_rst_n), .i_en (i_en),
        .i_imem_wen (i_imem_wen), .i_imem_waddr (i_imem_waddr), .i_imem_data (i_imem_data),
        .o_pc (o_pc), .o_instr (o_instr), .o_id_instr (id_instr)
    );

    decode_unit u_decode_unit (
        .clk (clk), .i_rst_n (i_rst_n), .i_en (i_en), .i_id_instr (id_instr),
        .i_du_rgfile_rd (i_du_rgfile_rd), .i_regfile_addr (i_regfile_addr),
        .i_wb_wen (wb_wen), .i_wb_rd (wb_rd), .i_wb_data (wb_data),
        .o_regfile_data (o_regfile_data),
        .o_ex_rs1_data (ex_rs1_data), .o_ex_rs2_data (ex_rs2_data), .o_ex_imm (ex_imm),
        .o_ex_rs1 (ex_rs1), .o_ex_rs2 (ex_rs2), .o_ex_rd (ex_rd),
        .o_ex_alu_op (ex_alu_op), .o_ex_alu_src_imm (ex_alu_src_imm),
        .o_ex_reg_write (ex_reg_write), .o_ex_mem_read (ex_mem_read),
        .o_ex_mem_write (ex_mem_write)
    );

    execute_unit u_execute_unit (
        .clk (clk), .i_rst_n (i_rst_n), .i_en (i_en),
        .i_ex_rs1_data (ex_rs1_data), .i_ex_rs2_data (ex_rs2_data), .i_ex_imm (ex_imm),
        .i_ex_rs1 (ex_rs1), .i_ex_rs2 (ex_rs2), .i_ex_rd (ex_rd),
        .i_ex_alu_op (ex_alu_op), .i_ex_alu_src_imm (ex_alu_src_imm),
        .i_ex_reg_write (ex_reg_write), .i_ex_mem_read (ex_mem_read),
        .i_ex_mem_write (ex_mem_write),
        .i_res_wen (wb_wen), .i_res_rd (wb_rd), .i_res_data (wb_data),
        .o_res_alu (res_alu), .o_res_store_data (res_store_data), .o_res_rd (res_rd),
        .o_res_reg_write (res_reg_write), .o_res_mem_read (res_mem_read),
        .o_res_mem_write (res_mem_write)
    );

    result_unit #(
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) u_result_unit (
        .clk (clk), .i_rst_n (i_rst_n), .i_en (i_en),
        .i_res_alu (res_alu), .i_res_store_data (res_store_data), .i_res_rd (res_rd),
        .i_res_reg_write (res_reg_write), .i_res_mem_read (res_mem_read),
        .i_res_mem_write (res_mem_write),
        .o_wb_wen (wb_wen), .o_wb_rd (wb_rd), .o_wb_data (wb_data)
    );

endmodule

// File: tests/tb_cpu_core.sv
/*
 * Testbench for the RV32I core
 * Loads the program from the testdata file, runs it with random enable
 * gaps and reads the registers back through the debug port
 */
`timescale 1ns/1ps

module tb_cpu_core;

    import cpu_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int IMEM_ADDR_WIDTH = 8;
    localparam int DMEM_ADDR_WIDTH = 5;
    localparam int IMEM_WORDS      = 2 ** (IMEM_ADDR_WIDTH - 2);
    localparam int TESTDATA_DEPTH  = 128;

    // Tag byte of each testdata entry
    localparam logic [7:0] TAG_PROG = 8'h01;
    localparam logic [7:0] TAG_RUN  = 8'h02;
    localparam logic [7:0] TAG_REG  = 8'h03;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_en;
    logic                       i_imem_wen;
    logic [IMEM_ADDR_WIDTH-1:0] i_imem_waddr;
    instr_t                     i_imem_data;
    logic                       i_du_rgfile_rd;
    reg_addr_t                  i_regfile_addr;
    pc_t                        o_pc;
    instr_t                     o_instr;
    data_t                      o_regfile_data;

    logic [47:0]                testdata [TESTDATA_DEPTH];
    instr_t                     imem_model [IMEM_WORDS];  // Expected instruction memory
    logic [IMEM_ADDR_WIDTH-1:0] prog_addr [$];
    instr_t                     prog_word [$];
    reg_addr_t                  exp_idx [$];
    data_t                      exp_val [$];
    int                         run_len;
    int                         cycle_count = 0;
    int                         cycle_limit = 0;  // Zero until the testdata is read
    logic [15:0]                lfsr_state;

    cpu_core #(
        .IMEM_ADDR_WIDTH (IMEM_ADDR_WIDTH),
        .DMEM_ADDR_WIDTH (DMEM_ADDR_WIDTH)
    ) cpu_core_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_en           (i_en),
        .i_imem_wen     (i_imem_wen),
        .i_imem_waddr   (i_imem_waddr),
        .i_imem_data    (i_imem_data),
        .i_du_rgfile_rd (i_du_rgfile_rd),
        .i_regfile_addr (i_regfile_addr),
        .o_pc           (o_pc),
        .o_instr        (o_instr),
        .o_regfile_data (o_regfile_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
            stop_with_error($sformatf("Timeout: the run did not end within %0d cycles",
                                      cycle_limit));
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic check_pc(input pc_t expected, input pc_t actual);
        if (actual !== expected)
            stop_with_error($sformatf("MISMATCH at %0t: o_pc expected %h, got %h",
                                      $time, expected, actual));
    endtask

    task automatic check_instr(input instr_t expected, input instr_t actual);
        if (actual !== expected)
            stop_with_error($sformatf("MISMATCH at %0t: o_instr expected %h, got %h",
                                      $time, expected, actual));
    endtask

    task automatic check_reg(input reg_addr_t idx, input data_t expected, input data_t actual);
        if (actual !== expected)
            stop_with_error($sformatf("MISMATCH at %0t: o_regfile_data (x%0d) expected %h, got %h",
                                      $time, idx, expected, actual));
    endtask

    task automatic parse_testdata();
        logic [47:0] entry;
        run_len = 0;
        for (int i = 0; i < TESTDATA_DEPTH; i++) begin
            entry = testdata[i];
            if (entry[47:40] === TAG_PROG) begin
                prog_addr.push_back(entry[39:32]);
                prog_word.push_back(entry[31:0]);
            end else if (entry[47:40] === TAG_RUN) begin
                run_len = int'(entry[31:0]);
            end else if (entry[47:40] === TAG_REG) begin
                exp_idx.push_back(entry[36:32]);
                exp_val.push_back(entry[31:0]);
            end else begin
                break;  // End of the file contents
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_word.size(); i++) begin
            @(negedge clk);
            check_pc(pc_t'(0), o_pc);
            check_instr(imem_model[0], o_instr);
            i_imem_wen   = 1'b1;
            i_imem_waddr = prog_addr[i];
            i_imem_data  = prog_word[i];
            imem_model[prog_addr[i][IMEM_ADDR_WIDTH-1:2]] = prog_word[i];
        end
        @(negedge clk);
        check_pc(pc_t'(0), o_pc);
        check_instr(imem_model[0], o_instr);
        i_imem_wen = 1'b0;
    endtask

    task automatic run_program();
        int   enabled;
        logic bit_a;
        logic bit_b;
        enabled = 0;
        while (enabled < run_len) begin
            @(negedge clk);
            check_pc(pc_t'(4 * enabled), o_pc);
            check_instr(imem_model[enabled % IMEM_WORDS], o_instr);
            lfsr_state = lfsr_next(lfsr_state);
            bit_a      = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            bit_b      = lfsr_state[0];
            i_en = !(bit_a && bit_b);  // Gap about one cycle in four
            if (i_en)
                enabled++;
        end
        @(negedge clk);
        i_en = 1'b0;
        check_pc(pc_t'(4 * run_len), o_pc);
    endtask

    task automatic read_back();
        for (int i = 0; i < exp_idx.size(); i++) begin
            @(negedge clk);
            i_du_rgfile_rd = 1'b1;
            i_regfile_addr = exp_idx[i];
            #(CLK_PERIOD / 4);
            check_reg(exp_idx[i], exp_val[i], o_regfile_data);
        end
        @(negedge clk);
        i_du_rgfile_rd = 1'b0;
    endtask

    initial begin
        i_rst_n        = 1'b0;
        i_en           = 1'b0;
        i_imem_wen     = 1'b0;
        i_imem_waddr   = '0;
        i_imem_data    = '0;
        i_du_rgfile_rd = 1'b0;
        i_regfile_addr = '0;
        lfsr_state     = 16'd52;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem_model[i] = '0;

        $readmemh("tests/cpu_testdata.txt", testdata);
        parse_testdata();
        if (prog_word.size() == 0 || run_len == 0 || exp_idx.size() == 0)
            stop_with_error("The testdata file lacks a program, a run length or expected values");
        cycle_limit = 2 * (prog_word.size() + run_len + exp_idx.size()) + 100;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        load_program();
        run_program();
        read_back();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tests/cpu_testdata.txt
// Columns: tag_index_value. Tag 01 is a program word at byte address index,
// tag 02 the number of enabled cycles, tag 03 the expected value of register index
01_00_00500093 // addi x1, x0, 5
01_04_00708113 // addi x2, x1, 7
01_08_002081B3 // add  x3, x1, x2
01_0C_40118233 // sub  x4, x3, x1
01_10_0020F2B3 // and  x5, x1, x2
01_14_0020E333 // or   x6, x1, x2
01_18_0020C3B3 // xor  x7, x1, x2
01_1C_FFD00493 // addi x9, x0, -3
01_20_0014A433 // slt  x8, x9, x1
01_24_00109533 // sll  x10, x1, x1
01_28_0014D5B3 // srl  x11, x9, x1
01_2C_12345637 // lui  x12, 0x12345
01_30_67866693 // ori  x13, x12, 0x678
01_34_0FF6F713 // andi x14, x13, 0xff
01_38_FFF6C793 // xori x15, x13, -1
01_3C_FFE4A813 // slti x16, x9, -2
01_40_00D02023 // sw   x13, 0(x0)
01_44_00F02223 // sw   x15, 4(x0)
01_48_00A02623 // sw   x10, 12(x0)
01_4C_00402883 // lw   x17, 4(x0)
01_50_00188933 // add  x18, x17, x1
01_54_FF422983 // lw   x19, -12(x4)
01_58_00022A03 // lw   x20, 0(x4)
01_5C_06300013 // addi x0, x0, 99
01_60_01202823 // sw   x18, 16(x0)
01_64_01002A83 // lw   x21, 16(x0)
02_00_00000020 // 32 enabled cycles
03_00_00000000
03_01_00000005
03_02_0000000C
03_03_00000011
03_04_0000000C
03_05_00000004
03_06_0000000D
03_07_00000009
03_08_00000001
03_09_FFFFFFFD
03_0A_000000A0
03_0B_07FFFFFF
03_0C_12345000
03_0D_12345678
03_0E_00000078
03_0F_EDCBA987
03_10_00000001
03_11_EDCBA987
03_12_EDCBA98C
03_13_12345678
03_14_000000A0
03_15_EDCBA98C

// File: flist.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_unit.sv
src/result_unit.sv
src/cpu_core.sv
tests/tb_cpu_core.sv
